//--- all.f
l2_pkg.sv
l2_arbiter.sv
l2_flush_walker.sv
l2_line_decoder.sv
l2_addr_decoder.sv
l2_input_decoder.sv
tb_clock_gen.sv
tb_checker.sv
l2_input_decoder_assert.sv
tb_l2_input_decoder.sv

//--- l2_addr_decoder.sv
`timescale 1ns/1ps

module l2_addr_decoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      decode_en,
    input  l2_pkg::decode_sel_t       sel_next,
    input  l2_pkg::addr_t             cpu_req_addr,
    input  logic [l2_pkg::set_bits:0] flush_set,
    output l2_pkg::addr_br_t          addr_br
);

    import l2_pkg::*;

    cpu_addr_u cpu_addr;
    addr_br_t  addr_br_d;

    // one word, two views
    assign cpu_addr = cpu_req_addr;

    always_comb begin
        // line base, offset cleared
        addr_br_d.line      = {cpu_addr.ln.line_addr, {offset_bits{1'b0}}};
        addr_br_d.line_addr = cpu_addr.ln.line_addr;
        // word base, byte offset cleared
        addr_br_d.word      = {cpu_addr.fld.tag, cpu_addr.fld.set, cpu_addr.fld.w_off,
                               {b_off_bits{1'b0}}};
        addr_br_d.tag       = cpu_addr.fld.tag;
        addr_br_d.w_off     = cpu_addr.fld.w_off;
        addr_br_d.b_off     = cpu_addr.fld.b_off;
        // flush steps index by walker set, whole line so offsets stay cpu ones
        if (sel_next.flush) begin
            addr_br_d.set = flush_set[set_bits-1:0];
        end else begin
            addr_br_d.set = cpu_addr.fld.set;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            addr_br <= '0;
        end else if (decode_en) begin
            addr_br <= addr_br_d;
        end
    end

endmodule

//--- l2_arbiter.sv
`timescale 1ns/1ps

module l2_arbiter #(
    parameter int n_mshr = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         decode_en,
    input  l2_pkg::in_valid_t            valid,
    input  l2_pkg::l2_state_t            state,
    input  logic [$clog2(n_mshr+1)-1:0]  mshr_cnt,
    input  l2_pkg::line_addr_t           rsp_in_addr,
    input  l2_pkg::line_addr_t           fwd_in_tmp_addr,
    input  logic                         ongoing_flush,
    input  logic [l2_pkg::set_bits:0]    flush_set,
    input  logic                         walk_done,
    output l2_pkg::in_ready_t            ready,
    output l2_pkg::decode_sel_t          sel_next,
    output l2_pkg::decode_sel_t          sel,
    output logic                         set_cpu_req_from_conflict,
    output logic                         set_fwd_in_from_stalled,
    output logic                         flush_start,
    output logic                         flush_finish
);

    import l2_pkg::*;

    localparam int cnt_bits = $clog2(n_mshr + 1);

    // free count equal to n_mshr means no entry in use
    localparam logic [cnt_bits-1:0] mshr_empty_cnt = cnt_bits'(n_mshr);

    logic mshr_empty;
    logic mshr_free;
    logic fwd_servable;
    logic rsp_collides;

    assign mshr_empty = (mshr_cnt == mshr_empty_cnt);
    assign mshr_free  = (mshr_cnt != '0);

    // new unstalled forward, or stalled one being replayed
    assign fwd_servable = (valid.fwd && !state.fwd_stall) || state.fwd_stall_ended;

    // response for the line a forward is about to touch waits
    assign rsp_collides = fwd_servable && (rsp_in_addr == fwd_in_tmp_addr);

    always_comb begin
        ready                     = '0;
        sel_next                  = '0;
        set_cpu_req_from_conflict = 1'b0;
        set_fwd_in_from_stalled   = 1'b0;
        flush_start               = 1'b0;
        flush_finish              = 1'b0;

        if (decode_en) begin
            if (valid.fence && !state.ongoing_fence) begin
                ready.fence    = 1'b1;
                sel_next.fence = 1'b1;
            end else if (valid.flush && mshr_empty) begin
                // start only, steps come later
                ready.flush = 1'b1;
                flush_start = 1'b1;
            end else if (valid.rsp && !mshr_empty && !rsp_collides) begin
                ready.rsp    = 1'b1;
                sel_next.rsp = 1'b1;
            end else if (fwd_servable) begin
                sel_next.fwd = 1'b1;
                if (!state.fwd_stall) begin
                    ready.fwd = 1'b1;
                end else begin
                    // replay from the stall register
                    set_fwd_in_from_stalled = 1'b1;
                end
            end else if (state.ongoing_fence) begin
                sel_next.ongoing_fence = 1'b1;
            end else if (ongoing_flush) begin
                if (flush_set < l2_sets) begin
                    // one way per step, forwards go first
                    if (!valid.fwd && mshr_free) begin
                        sel_next.flush = 1'b1;
                    end
                end else if (walk_done && mshr_empty) begin
                    // all ways written back, tell the walker to stop
                    flush_finish = 1'b1;
                end
            end else if ((valid.cpu_req || state.set_conflict) && mshr_free
                         && !state.evict_stall) begin
                sel_next.cpu_req = 1'b1;
                if (!state.set_conflict) begin
                    ready.cpu_req = 1'b1;
                end else begin
                    // conflicted request replays first
                    set_cpu_req_from_conflict = 1'b1;
                end
            end
        end
    end

    // selection seen by the pipeline one cycle later
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sel <= '0;
        end else if (decode_en) begin
            sel <= sel_next;
        end
    end

endmodule

//--- l2_flush_walker.sv
`timescale 1ns/1ps

module l2_flush_walker #(
    parameter int l2_ways = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush_start,
    input  logic                      flush_step,
    input  logic                      flush_finish,
    output logic                      ongoing_flush,
    output logic [l2_pkg::set_bits:0] flush_set,
    output logic                      walk_done,
    output logic                      flush_done
);

    import l2_pkg::*;

    // at least one bit even for a direct mapped cache
    localparam int way_bits = (l2_ways > 1) ? $clog2(l2_ways) : 1;
    localparam logic [way_bits-1:0] way_last = way_bits'(l2_ways - 1);

    logic [way_bits-1:0] flush_way;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ongoing_flush <= 1'b0;
            flush_set     <= '0;
            flush_way     <= '0;
        end else if (flush_start || flush_finish) begin
            // both ends of a flush restart the walk at set 0 way 0
            ongoing_flush <= flush_start;
            flush_set     <= '0;
            flush_way     <= '0;
        end else if (flush_step) begin
            if (flush_way == way_last) begin
                // wrap way, move to next set
                flush_way <= '0;
                flush_set <= flush_set + 1'b1;
            end else begin
                flush_way <= flush_way + 1'b1;
            end
        end
    end

    // top bit set means counter ran past the last set
    assign walk_done = ongoing_flush && flush_set[set_bits];

    // completion pulse in the finishing cycle
    assign flush_done = flush_finish;

endmodule

//--- l2_input_decoder.sv
`timescale 1ns/1ps

module l2_input_decoder #(
    parameter int n_mshr  = 4,
    parameter int l2_ways = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        decode_en,
    input  l2_pkg::in_valid_t           valid,
    input  l2_pkg::l2_state_t           state,
    input  logic [$clog2(n_mshr+1)-1:0] mshr_cnt,
    input  l2_pkg::line_addr_t          rsp_in_addr,
    input  l2_pkg::line_addr_t          fwd_in_addr,
    input  l2_pkg::line_addr_t          fwd_in_tmp_addr,
    input  l2_pkg::addr_t               cpu_req_addr,
    output l2_pkg::in_ready_t           ready,
    output l2_pkg::decode_sel_t         sel,
    output logic                        set_cpu_req_from_conflict,
    output logic                        set_fwd_in_from_stalled,
    output logic                        flush_done,
    output l2_pkg::line_br_t            line_br,
    output l2_pkg::addr_br_t            addr_br
);

    import l2_pkg::*;

    // arbiter to walker and decoders
    decode_sel_t sel_next;
    logic        flush_start;
    logic        flush_finish;

    // walker back to arbiter
    logic                ongoing_flush;
    logic [set_bits:0]   flush_set;
    logic                walk_done;

    l2_arbiter #(
        .n_mshr(n_mshr)
    ) u_arbiter (
        .clk                       (clk),
        .rst                       (rst),
        .decode_en                 (decode_en),
        .valid                     (valid),
        .state                     (state),
        .mshr_cnt                  (mshr_cnt),
        .rsp_in_addr               (rsp_in_addr),
        .fwd_in_tmp_addr           (fwd_in_tmp_addr),
        .ongoing_flush             (ongoing_flush),
        .flush_set                 (flush_set),
        .walk_done                 (walk_done),
        .ready                     (ready),
        .sel_next                  (sel_next),
        .sel                       (sel),
        .set_cpu_req_from_conflict (set_cpu_req_from_conflict),
        .set_fwd_in_from_stalled   (set_fwd_in_from_stalled),
        .flush_start               (flush_start),
        .flush_finish              (flush_finish)
    );

    // a flush step is the flush bit of the next selection
    l2_flush_walker #(
        .l2_ways(l2_ways)
    ) u_flush_walker (
        .clk           (clk),
        .rst           (rst),
        .flush_start   (flush_start),
        .flush_step    (sel_next.flush),
        .flush_finish  (flush_finish),
        .ongoing_flush (ongoing_flush),
        .flush_set     (flush_set),
        .walk_done     (walk_done),
        .flush_done    (flush_done)
    );

    l2_line_decoder u_line_decoder (
        .clk         (clk),
        .rst         (rst),
        .decode_en   (decode_en),
        .sel_next    (sel_next),
        .rsp_in_addr (rsp_in_addr),
        .fwd_in_addr (fwd_in_addr),
        .line_br     (line_br)
    );

    l2_addr_decoder u_addr_decoder (
        .clk          (clk),
        .rst          (rst),
        .decode_en    (decode_en),
        .sel_next     (sel_next),
        .cpu_req_addr (cpu_req_addr),
        .flush_set    (flush_set),
        .addr_br      (addr_br)
    );

endmodule

//--- l2_input_decoder_assert.sv
`timescale 1ns/1ps

module l2_input_decoder_assert (
    input logic                clk,
    input logic                rst,
    input l2_pkg::in_valid_t   valid,
    input l2_pkg::in_ready_t   ready,
    input l2_pkg::decode_sel_t sel,
    input logic                flush_done,
    input logic                ongoing_flush
);

    // one stream accepted per cycle
    ready_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot0(ready))
        else $error("more than one ready high");

    // completion only comes out of a running flush
    done_needs_flush: assert property (@(posedge clk) disable iff (!rst)
        flush_done |-> (valid != '0 || ongoing_flush))
        else $error("flush_done without valid or ongoing flush");

    sel_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot0(sel))
        else $error("registered selection not one-hot");

endmodule

bind l2_input_decoder l2_input_decoder_assert u_assert (
    .clk           (clk),
    .rst           (rst),
    .valid         (valid),
    .ready         (ready),
    .sel           (sel),
    .flush_done    (flush_done),
    .ongoing_flush (ongoing_flush)
);

//--- l2_line_decoder.sv
`timescale 1ns/1ps

module l2_line_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                decode_en,
    input  l2_pkg::decode_sel_t sel_next,
    input  l2_pkg::line_addr_t  rsp_in_addr,
    input  l2_pkg::line_addr_t  fwd_in_addr,
    output l2_pkg::line_br_t    line_br
);

    import l2_pkg::*;

    line_addr_t line_addr;
    line_br_t   line_br_d;

    // response wins over forward, nothing else carries a line address
    always_comb begin
        if (sel_next.rsp) begin
            line_addr = rsp_in_addr;
        end else if (sel_next.fwd) begin
            line_addr = fwd_in_addr;
        end else begin
            line_addr = '0;
        end
        // set in the low bits, tag above
        line_br_d.tag = line_addr[line_bits-1:set_bits];
        line_br_d.set = line_addr[set_bits-1:0];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            line_br <= '0;
        end else if (decode_en) begin
            line_br <= line_br_d;
        end
    end

endmodule

//--- l2_pkg.sv
package l2_pkg;

    // address geometry
    localparam int addr_bits   = 32;
    localparam int offset_bits = 4;
    localparam int w_off_bits  = 2;
    localparam int b_off_bits  = 2;
    localparam int set_bits    = 4;
    localparam int tag_bits    = addr_bits - offset_bits - set_bits;
    localparam int line_bits   = addr_bits - offset_bits;

    // number of l2 sets follows the set index width
    localparam int l2_sets = 1 << set_bits;

    typedef logic [line_bits-1:0] line_addr_t;
    typedef logic [addr_bits-1:0] addr_t;

    // response / forward line split
    typedef struct packed {
        logic [tag_bits-1:0] tag;
        logic [set_bits-1:0] set;
    } line_br_t;

    // full cpu address breakdown
    typedef struct packed {
        addr_t                 line;
        line_addr_t            line_addr;
        addr_t                 word;
        logic [tag_bits-1:0]   tag;
        logic [set_bits-1:0]   set;
        logic [w_off_bits-1:0] w_off;
        logic [b_off_bits-1:0] b_off;
    } addr_br_t;

    // field view of a cpu address
    typedef struct packed {
        logic [tag_bits-1:0]   tag;
        logic [set_bits-1:0]   set;
        logic [w_off_bits-1:0] w_off;
        logic [b_off_bits-1:0] b_off;
    } cpu_fields_t;

    // line view of the same address
    typedef struct packed {
        line_addr_t             line_addr;
        logic [offset_bits-1:0] off;
    } cpu_line_t;

    typedef union packed {
        cpu_fields_t fld;
        cpu_line_t   ln;
    } cpu_addr_u;

    // one bit per incoming stream
    typedef struct packed {
        logic fence;
        logic flush;
        logic rsp;
        logic fwd;
        logic cpu_req;
    } in_valid_t;

    typedef struct packed {
        logic fence;
        logic flush;
        logic rsp;
        logic fwd;
        logic cpu_req;
    } in_ready_t;

    // what got picked this cycle
    typedef struct packed {
        logic fence;
        logic flush;
        logic rsp;
        logic fwd;
        logic ongoing_fence;
        logic cpu_req;
    } decode_sel_t;

    // controller state flags
    typedef struct packed {
        logic evict_stall;
        logic set_conflict;
        logic fwd_stall;
        logic fwd_stall_ended;
        logic ongoing_fence;
    } l2_state_t;

endpackage

//--- l2_testdata.txt
# name en valid state mshr rsp_addr fwd_addr tmp_addr cpu_addr cpu_mask rep ready sel cc fs fd
# all fields after the name are hex; cpu bits under the mask come from the lfsr
prio_all 1 1f 00 2 0123456 0abcdef 0fff000 00000000 ffffffff 1 10 20 0 0 0
prio_rsp 1 0f 00 2 0123456 0abcdef 0fff000 00000000 ffffffff 1 04 08 0 0 0
collide 1 06 00 2 0555555 0abcdef 0555555 00000000 0000ffff 1 02 04 0 0 0
stall_wait 1 02 04 2 0555555 0abcdef 0555555 00000000 0000ffff 1 00 00 0 0 0
stall_end 1 02 06 2 0111111 0fedcba 0222222 00000000 0000ffff 1 00 04 0 1 0
cpu_req 1 01 00 2 0000000 0000000 0000000 12345678 0000ffff 1 01 01 0 0 0
cpu_rand 1 01 00 1 0000000 0000000 0000000 00000000 ffffffff 3 01 01 0 0 0
hold_off 0 1f 00 2 0123456 0abcdef 0fff000 00000000 ffffffff 3 00 00 0 0 0
conflict 1 00 08 2 0000000 0000000 0000000 00000000 ffffffff 1 00 01 1 0 0
evict 1 01 10 2 0000000 0000000 0000000 00000000 ffffffff 1 00 00 0 0 0
no_mshr 1 01 00 0 0000000 0000000 0000000 00000000 ffffffff 1 00 00 0 0 0
ong_fence 1 01 01 2 0000000 0000000 0000000 00000000 ffffffff 1 00 02 0 0 0
fence_busy 1 10 01 2 0000000 0000000 0000000 00000000 ffffffff 1 00 02 0 0 0
flush_start 1 08 00 4 0000000 0000000 0000000 00000000 ffffffff 1 08 00 0 0 0
flush_walk_a 1 00 00 2 0000000 0000000 0000000 00000000 ffffffff 14 00 10 0 0 0
flush_fwd 1 02 00 2 0000000 0333333 0444444 00000000 ffffffff 1 02 04 0 0 0
flush_walk_b 1 00 00 2 0000000 0000000 0000000 00000000 ffffffff 2c 00 10 0 0 0
flush_wait 1 00 00 2 0000000 0000000 0000000 00000000 ffffffff 2 00 00 0 0 0
flush_end 1 00 00 4 0000000 0000000 0000000 00000000 ffffffff 1 00 00 0 0 1
after_flush 1 01 00 4 0000000 0000000 0000000 00000000 ffffffff 1 01 01 0 0 0

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_l2_input_decoder

out=$(./obj_dir/Vtb_l2_input_decoder)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                check_en,
    input  logic                last,
    input  logic                finished,
    input  logic [127:0]        name,
    input  l2_pkg::in_ready_t   exp_ready,
    input  logic                exp_cc,
    input  logic                exp_fs,
    input  logic                exp_fd,
    input  l2_pkg::decode_sel_t exp_sel,
    input  l2_pkg::line_br_t    exp_line_br,
    input  l2_pkg::addr_br_t    exp_addr_br,
    input  l2_pkg::in_ready_t   ready,
    input  logic                set_cpu_req_from_conflict,
    input  logic                set_fwd_in_from_stalled,
    input  logic                flush_done,
    input  l2_pkg::decode_sel_t sel,
    input  l2_pkg::line_br_t    line_br,
    input  l2_pkg::addr_br_t    addr_br,
    output int                  test_count,
    output int                  fail_tests
);

    import l2_pkg::*;

    // registered expectations wait here for one clock
    logic         pend;
    logic         pend_last;
    logic [127:0] pend_name;
    decode_sel_t  pend_sel;
    line_br_t     pend_line_br;
    addr_br_t     pend_addr_br;
    int           test_errs;

    initial begin
        pend       = 1'b0;
        test_errs  = 0;
        test_count = 0;
        fail_tests = 0;
    end

    // comb outputs, read before the edge updates anything
    always @(posedge clk) begin
        pend <= 1'b0;
        if (rst && check_en) begin
            if (ready !== exp_ready) begin
                $display("FAILED %0s ready expected %h actual %h", name, exp_ready, ready);
                test_errs++;
            end
            if (set_cpu_req_from_conflict !== exp_cc) begin
                $display("FAILED %0s conflict strobe expected %b actual %b", name, exp_cc,
                         set_cpu_req_from_conflict);
                test_errs++;
            end
            if (set_fwd_in_from_stalled !== exp_fs) begin
                $display("FAILED %0s stalled strobe expected %b actual %b", name, exp_fs,
                         set_fwd_in_from_stalled);
                test_errs++;
            end
            if (flush_done !== exp_fd) begin
                $display("FAILED %0s flush_done expected %b actual %b", name, exp_fd,
                         flush_done);
                test_errs++;
            end
            pend         <= 1'b1;
            pend_last    <= last;
            pend_name    <= name;
            pend_sel     <= exp_sel;
            pend_line_br <= exp_line_br;
            pend_addr_br <= exp_addr_br;
        end
    end

    // registered outputs settled half a clock after the edge
    always @(negedge clk) begin
        if (pend) begin
            if (sel !== pend_sel) begin
                $display("FAILED %0s sel expected %h actual %h", pend_name, pend_sel, sel);
                test_errs++;
            end
            if (line_br !== pend_line_br) begin
                $display("FAILED %0s line_br expected %h actual %h", pend_name,
                         pend_line_br, line_br);
                test_errs++;
            end
            if (addr_br !== pend_addr_br) begin
                $display("FAILED %0s addr_br expected %h actual %h", pend_name,
                         pend_addr_br, addr_br);
                test_errs++;
            end
            if (pend_last) begin
                test_count++;
                if (test_errs == 0) begin
                    $display("test %0s ok", pend_name);
                end else begin
                    $display("test %0s failed with %0d mismatches", pend_name, test_errs);
                    fail_tests++;
                end
                test_errs = 0;
            end
        end
    end

    always @(posedge finished) begin
        $display("tests run %0d, failed %0d", test_count, fail_tests);
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns   = 40,
    parameter int rst_cycles  = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // active low, released on a falling edge
    initial begin
        rst = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

//--- tb_l2_input_decoder.sv
`timescale 1ns/1ps

module tb_l2_input_decoder;

    import l2_pkg::*;

    localparam int n_mshr  = 4;
    localparam int l2_ways = 4;
    localparam int max_vec = 64;

    logic clk;
    logic rst;

    // dut inputs
    logic                        decode_en;
    in_valid_t                   valid;
    l2_state_t                   state;
    logic [$clog2(n_mshr+1)-1:0] mshr_cnt;
    line_addr_t                  rsp_in_addr;
    line_addr_t                  fwd_in_addr;
    line_addr_t                  fwd_in_tmp_addr;
    addr_t                       cpu_req_addr;

    // dut outputs
    in_ready_t   ready;
    decode_sel_t sel;
    logic        set_cpu_req_from_conflict;
    logic        set_fwd_in_from_stalled;
    logic        flush_done;
    line_br_t    line_br;
    addr_br_t    addr_br;

    // expectations handed to the checker
    logic         check_en;
    logic         last;
    logic         finished;
    logic [127:0] name;
    in_ready_t    exp_ready;
    logic         exp_cc;
    logic         exp_fs;
    logic         exp_fd;
    decode_sel_t  exp_sel;
    line_br_t     exp_line_br;
    addr_br_t     exp_addr_br;
    int           test_count;
    int           fail_tests;

    // vectors from the data file
    logic [127:0] v_name [max_vec];
    logic [31:0]  v_en [max_vec];
    logic [31:0]  v_valid [max_vec];
    logic [31:0]  v_state [max_vec];
    logic [31:0]  v_mshr [max_vec];
    logic [31:0]  v_rsp [max_vec];
    logic [31:0]  v_fwd [max_vec];
    logic [31:0]  v_tmp [max_vec];
    logic [31:0]  v_cpu [max_vec];
    logic [31:0]  v_mask [max_vec];
    logic [31:0]  v_rep [max_vec];
    logic [31:0]  v_ready [max_vec];
    logic [31:0]  v_sel [max_vec];
    logic [31:0]  v_cc [max_vec];
    logic [31:0]  v_fs [max_vec];
    logic [31:0]  v_fd [max_vec];
    int           n_vec;
    int           total_reps;
    logic         loaded;
    logic [15:0]  lfsr;
    int           flush_steps;

    tb_clock_gen #(.period_ns(40), .rst_cycles(2)) u_clock_gen (.clk(clk), .rst(rst));

    l2_input_decoder #(
        .n_mshr  (n_mshr),
        .l2_ways (l2_ways)
    ) u_l2_input_decoder (
        .clk                       (clk),
        .rst                       (rst),
        .decode_en                 (decode_en),
        .valid                     (valid),
        .state                     (state),
        .mshr_cnt                  (mshr_cnt),
        .rsp_in_addr               (rsp_in_addr),
        .fwd_in_addr               (fwd_in_addr),
        .fwd_in_tmp_addr           (fwd_in_tmp_addr),
        .cpu_req_addr              (cpu_req_addr),
        .ready                     (ready),
        .sel                       (sel),
        .set_cpu_req_from_conflict (set_cpu_req_from_conflict),
        .set_fwd_in_from_stalled   (set_fwd_in_from_stalled),
        .flush_done                (flush_done),
        .line_br                   (line_br),
        .addr_br                   (addr_br)
    );

    tb_checker u_checker (
        .clk                       (clk),
        .rst                       (rst),
        .check_en                  (check_en),
        .last                      (last),
        .finished                  (finished),
        .name                      (name),
        .exp_ready                 (exp_ready),
        .exp_cc                    (exp_cc),
        .exp_fs                    (exp_fs),
        .exp_fd                    (exp_fd),
        .exp_sel                   (exp_sel),
        .exp_line_br               (exp_line_br),
        .exp_addr_br               (exp_addr_br),
        .ready                     (ready),
        .set_cpu_req_from_conflict (set_cpu_req_from_conflict),
        .set_fwd_in_from_stalled   (set_fwd_in_from_stalled),
        .flush_done                (flush_done),
        .sel                       (sel),
        .line_br                   (line_br),
        .addr_br                   (addr_br),
        .test_count                (test_count),
        .fail_tests                (fail_tests)
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // masked bits come from the lfsr, one step per bit
    task automatic fill_masked(input logic [31:0] fixed, input logic [31:0] mask,
                               output logic [31:0] addr);
        addr = fixed;
        for (int i = 0; i < 32; i++) begin
            if (mask[i]) begin
                addr[i] = lfsr[15];
                lfsr = lfsr_next(lfsr);
            end
        end
    endtask

    // tag/set/offsets straight from the address bits
    function automatic addr_br_t slice_addr(input logic [31:0] a, input logic [3:0] set);
        return {a[31:4], 4'h0, a[31:4], a[31:2], 2'b00, a[31:8], set, a[3:2], a[1:0]};
    endfunction

    task automatic load_vectors();
        int    fd;
        int    cnt;
        string text;
        fd = $fopen("l2_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open l2_testdata.txt");
        end else begin
            while (!$feof(fd) && n_vec < max_vec) begin
                text = "";
                void'($fgets(text, fd));
                if (text.len() > 2 && text[0] != "#") begin
                    cnt = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  v_name[n_vec], v_en[n_vec], v_valid[n_vec],
                                  v_state[n_vec], v_mshr[n_vec], v_rsp[n_vec],
                                  v_fwd[n_vec], v_tmp[n_vec], v_cpu[n_vec], v_mask[n_vec],
                                  v_rep[n_vec], v_ready[n_vec], v_sel[n_vec], v_cc[n_vec],
                                  v_fs[n_vec], v_fd[n_vec]);
                    if (cnt == 16) begin
                        total_reps += v_rep[n_vec];
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_vector(input int v, input bit is_last);
        logic [31:0] cpu;
        logic [3:0]  set;
        decode_en       = v_en[v][0];
        valid           = v_valid[v][4:0];
        state           = v_state[v][4:0];
        mshr_cnt        = v_mshr[v][2:0];
        rsp_in_addr     = v_rsp[v][27:0];
        fwd_in_addr     = v_fwd[v][27:0];
        fwd_in_tmp_addr = v_tmp[v][27:0];
        fill_masked(v_cpu[v], v_mask[v], cpu);
        cpu_req_addr    = cpu;
        name            = v_name[v];
        last            = is_last;
        exp_ready       = v_ready[v][4:0];
        exp_cc          = v_cc[v][0];
        exp_fs          = v_fs[v][0];
        exp_fd          = v_fd[v][0];
        if (exp_ready.flush) begin
            flush_steps = 0;
        end
        // registers only follow while enabled
        if (decode_en) begin
            exp_sel = v_sel[v][5:0];
            set     = cpu[7:4];
            if (exp_sel.flush) begin
                set = 4'(flush_steps / l2_ways);
                flush_steps++;
            end
            exp_addr_br = slice_addr(cpu, set);
            if (exp_sel.rsp) begin
                exp_line_br = rsp_in_addr;
            end else if (exp_sel.fwd) begin
                exp_line_br = fwd_in_addr;
            end else begin
                exp_line_br = '0;
            end
        end
        check_en = 1'b1;
    endtask

    initial begin
        decode_en       = 1'b0;
        valid           = '0;
        state           = '0;
        mshr_cnt        = '0;
        rsp_in_addr     = '0;
        fwd_in_addr     = '0;
        fwd_in_tmp_addr = '0;
        cpu_req_addr    = '0;
        check_en        = 1'b0;
        last            = 1'b0;
        finished        = 1'b0;
        name            = '0;
        exp_ready       = '0;
        exp_cc          = 1'b0;
        exp_fs          = 1'b0;
        exp_fd          = 1'b0;
        exp_sel         = '0;
        exp_line_br     = '0;
        exp_addr_br     = '0;
        n_vec           = 0;
        total_reps      = 0;
        flush_steps     = 0;
        lfsr            = 16'd22;
        loaded          = 1'b0;
        load_vectors();
        loaded = 1'b1;
        wait (rst === 1'b1);
        for (int v = 0; v < n_vec; v++) begin
            for (int r = 0; r < int'(v_rep[v]); r++) begin
                @(negedge clk);
                apply_vector(v, r == int'(v_rep[v]) - 1);
            end
        end
        @(negedge clk);
        check_en  = 1'b0;
        decode_en = 1'b0;
        @(negedge clk);
        finished = 1'b1;
        #1;
        if (fail_tests == 0 && test_count == n_vec && n_vec > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // every vector cycle plus a full flush walk and some slack
    initial begin
        int limit_ns;
        wait (loaded === 1'b1);
        limit_ns = (total_reps + l2_sets * l2_ways + 20) * 40;
        #(limit_ns);
        $display("run did not finish within %0d ns", limit_ns);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
